// File: dv/softermax_model.sv
`default_nettype none
`include "softermax_settings.svh"

package softermax_model;

    typedef int row_t [`SM_ROW_LEN];

    // 2^(f/4) in sixteenths
    localparam int POW2_Q4 [4] = '{16, 19, 23, 27};

    // a sixteenth of the table times this is 2^-15 of the exponential
    localparam int     EXP_LUT_SCALE = 1 << (`SM_EXP_W - 5);
    localparam longint PROB_ONE      = 64'd1 << (`SM_PROB_W - 1);
    localparam longint DEN_MASK      = (64'd1 << `SM_DEN_W) - 1;

    // long shifts clear the word
    function automatic longint shr(input longint x, input int n);
        if (n >= 48) begin
            return 0;
        end
        return x >> n;
    endfunction

    // scores are signed values in quarters, probabilities have 1.0 at 2^15
    function automatic void compute_row(input row_t scores, output row_t probs);
        int     ip;
        int     fr;
        int     c;
        int     m;
        int     m_new;
        longint d;
        longint v;
        longint q;
        row_t   u;
        row_t   lm;
        m = 0;
        d = 0;
        for (int i = 0; i < `SM_ROW_LEN; i++) begin
            ip    = scores[i] >>> `SM_FRAC_W;
            fr    = scores[i] & ((1 << `SM_FRAC_W) - 1);
            c     = (fr != 0) ? ip + 1 : ip;
            m_new = (i == 0 || c > m) ? c : m;
            u[i]  = int'(shr(POW2_Q4[fr] * EXP_LUT_SCALE, m_new - ip));
            if (i == 0) begin
                d = u[i];
            end else begin
                // old terms follow the max upward
                d = (shr(d, m_new - m) + u[i]) & DEN_MASK;
            end
            m     = m_new;
            lm[i] = m;
        end
        for (int i = 0; i < `SM_ROW_LEN; i++) begin
            v        = shr(u[i], m - lm[i]);
            q        = (v * PROB_ONE) / d;
            probs[i] = int'((q > PROB_ONE) ? PROB_ONE : q);
        end
    endfunction

endpackage

`default_nettype wire

// File: dv/tb_softermax.sv
`timescale 1ns/1ps
`default_nettype none
`include "softermax_settings.svh"

module tb_softermax;
    import softermax_model::*;

    localparam int ROW_LEN      = `SM_ROW_LEN;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_GAP      = 3;
    // scores with gaps, pipeline drain, then a read, a start and 16 steps per element
    localparam int ROW_CYCLES   = ROW_LEN * (MAX_GAP + 1) + 8 + ROW_LEN * 18;
    localparam int SWEEP_CYCLES = ROW_LEN + 4;
    localparam int NUM_ROWS     = 4;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_ROWS * (ROW_CYCLES + SWEEP_CYCLES) + 200;

    logic                        clk;
    logic                        rst_n;
    logic                        in_valid;
    softermax_num_pkg::sm_data_t in_data;
    softermax_ctrl_pkg::sm_idx_t read_addr;
    logic                        norm_valid;
    logic                        final_out_valid;
    softermax_num_pkg::sm_prob_t prob_out;

    integer                      seed = 32'hdb4a4eb4;
    string                       test_name;
    int                          fail_cnt = 0;
    int                          fails_at_start;
    int                          test_cnt = 0;
    int                          tests_failed = 0;
    int                          cycle_cnt = 0;
    logic                        reset_window = 1'b0;
    logic                        sweep_en = 1'b0;
    logic                        chk_en = 1'b0;
    softermax_ctrl_pkg::sm_idx_t chk_addr;
    int                          chk_exp;
    row_t                        exp_prob;
    row_t                        row;

    softermax_top u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_data         (in_data),
        .read_addr       (read_addr),
        .norm_valid      (norm_valid),
        .final_out_valid (final_out_valid),
        .prob_out        (prob_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles", cycle_cnt);
            $display("Testbench failed");
            $finish;
        end
    end

    // prob_out lags read_addr by one cycle
    always @(posedge clk) begin
        chk_en   <= sweep_en;
        chk_addr <= read_addr;
        chk_exp  <= exp_prob[read_addr];
    end

    assert property (@(posedge clk)
        reset_window |-> (!norm_valid && !final_out_valid && prob_out == '0))
    else begin
        $display("FAIL %s: outputs expected 0, actual norm_valid %b final_out_valid %b prob_out %0d",
                 test_name, $sampled(norm_valid), $sampled(final_out_valid), $sampled(prob_out));
        fail_cnt++;
    end

    assert property (@(posedge clk) chk_en |-> (int'(prob_out) == chk_exp))
    else begin
        $display("FAIL %s: prob[%0d] expected %0d, actual %0d",
                 test_name, $sampled(chk_addr), $sampled(chk_exp), $sampled(prob_out));
        fail_cnt++;
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(norm_valid && final_out_valid))
    else begin
        $display("%s: norm_valid and final_out_valid are high together", test_name);
        fail_cnt++;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(final_out_valid) |-> $past(norm_valid))
    else begin
        $display("%s: final_out_valid rose without a second pass before it", test_name);
        fail_cnt++;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        norm_valid |=> (norm_valid || final_out_valid))
    else begin
        $display("%s: norm_valid fell before the row was complete", test_name);
        fail_cnt++;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (final_out_valid && !in_valid) |=> final_out_valid)
    else begin
        $display("%s: final_out_valid fell with no new score", test_name);
        fail_cnt++;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (final_out_valid && in_valid) |=> !final_out_valid)
    else begin
        $display("%s: final_out_valid stayed high after the next row started", test_name);
        fail_cnt++;
    end

    task automatic start_test(input string name);
        test_name      = name;
        fails_at_start = fail_cnt;
    endtask

    task automatic end_test();
        test_cnt++;
        if (fail_cnt == fails_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d check(s) failed", test_name, fail_cnt - fails_at_start);
        end
    endtask

    task automatic send_row(input row_t scores, input int max_gap);
        logic [31:0] r;
        for (int i = 0; i < ROW_LEN; i++) begin
            @(posedge clk);
            in_valid    <= 1'b1;
            in_data.raw <= scores[i][7:0];
            r = $random(seed);
            for (int g = 0; g < int'(r % (max_gap + 1)); g++) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic sweep_probs();
        for (int a = 0; a < ROW_LEN; a++) begin
            @(posedge clk);
            read_addr <= softermax_ctrl_pkg::sm_idx_t'(a);
            sweep_en  <= 1'b1;
        end
        @(posedge clk);
        sweep_en <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    // extra scores go in while the row is being divided
    task automatic run_row(input row_t scores, input int max_gap, input int extras);
        logic [31:0] r;
        send_row(scores, max_gap);
        @(negedge clk);
        while (!norm_valid) @(negedge clk);
        for (int k = 0; k < extras; k++) begin
            r = $random(seed);
            @(posedge clk);
            in_valid    <= 1'b1;
            in_data.raw <= r[7:0];
            @(posedge clk);
            in_valid <= 1'b0;
        end
        @(negedge clk);
        while (!final_out_valid) @(negedge clk);
        sweep_probs();
    endtask

    initial begin
        logic [31:0] r;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        read_addr = '0;

        start_test("reset");
        // the first edge in reset clears the registers
        @(posedge clk);
        reset_window <= 1'b1;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        reset_window <= 1'b0;
        repeat (2) @(posedge clk);
        end_test();

        // 1.25 everywhere, so each share is 1/16
        start_test("uniform");
        for (int i = 0; i < ROW_LEN; i++) begin
            row[i]      = 5;
            exp_prob[i] = 1 << (`SM_PROB_W - 1 - 4);
        end
        run_row(row, 0, 0);
        end_test();

        start_test("ascending");
        for (int i = 0; i < ROW_LEN; i++) begin
            row[i] = 7 * i - 50;
        end
        compute_row(row, exp_prob);
        run_row(row, 0, 0);
        end_test();

        start_test("random_gaps");
        for (int i = 0; i < ROW_LEN; i++) begin
            r      = $random(seed);
            row[i] = int'($signed(r[7:0]));
        end
        compute_row(row, exp_prob);
        run_row(row, MAX_GAP, 5);
        end_test();

        // final_out_valid is still up from the last row
        start_test("second_row");
        repeat (6) @(posedge clk);
        for (int i = 0; i < ROW_LEN; i++) begin
            row[i] = 40 - 5 * i;
        end
        compute_row(row, exp_prob);
        run_row(row, 0, 0);
        end_test();

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 test_cnt, tests_failed, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
logic/softermax_num_pkg.sv
logic/softermax_ctrl_pkg.sv
logic/softermax_ctrl.sv
logic/online_exp_unit.sv
logic/denom_accum.sv
logic/row_store.sv
logic/prob_normalizer.sv
logic/softermax_top.sv
dv/softermax_model.sv
dv/tb_softermax.sv

// File: include/softermax_settings.svh
`ifndef SOFTERMAX_SETTINGS_SVH
`define SOFTERMAX_SETTINGS_SVH

// score word, signed with two fraction bits
`define SM_DATA_W    8
`define SM_FRAC_W    2

// scores per row
`define SM_ROW_LEN   16

// exponential and probability words, top bit is 1.0
`define SM_EXP_W     16
`define SM_PROB_W    16

// wide enough for a full row of 1.0 terms
`define SM_DEN_W     21

// one quotient bit per step
`define SM_DIV_STEPS 16

`endif

// File: logic/denom_accum.sv
`timescale 1ns/1ps
`default_nettype none

module denom_accum (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         exp_valid,
    input  logic                         elem_first_d,
    input  softermax_num_pkg::sm_exp_t   exp_val,
    input  softermax_num_pkg::sm_shift_t max_growth,
    output softermax_num_pkg::sm_den_t   denom
);
    import softermax_num_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            denom <= '0;
        end else if (exp_valid) begin
            if (elem_first_d) begin
                denom <= sm_den_t'(exp_val);
            end else begin
                // earlier terms move down to the new max
                denom <= (denom >> max_growth) + sm_den_t'(exp_val);
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/online_exp_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "softermax_settings.svh"

module online_exp_unit (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         accept,
    input  logic                         elem_first,
    input  softermax_num_pkg::sm_data_t  in_data,
    output logic                         exp_valid,
    output softermax_ctrl_pkg::sm_idx_t  exp_idx,
    output softermax_num_pkg::sm_exp_t   exp_val,
    output softermax_num_pkg::sm_int_t   run_max,
    output softermax_num_pkg::sm_shift_t max_growth,
    output logic                         elem_first_d
);
    import softermax_num_pkg::*;
    import softermax_ctrl_pkg::*;

    // lut entry 16 lands on the top bit of the exponential
    localparam int unsigned LUT_SCALE = `SM_EXP_W - 1 - SM_POW2_UNIT_W;

    sm_int_t   in_int;
    sm_int_t   in_ceil;
    sm_int_t   max_q;
    sm_int_t   max_next;
    sm_idx_t   idx_cnt;
    sm_idx_t   idx_next;
    logic      s1_valid;
    logic      s1_first;
    sm_data_t  s1_data;
    sm_idx_t   s1_idx;
    sm_shift_t s1_growth;
    sm_int_t   s1_int;
    sm_exp_t   pow_frac;

    // ceiling of the score
    assign in_int   = $signed(in_data.fields.int_part);
    assign in_ceil  = in_int + sm_int_t'(in_data.fields.frac_part != '0);
    // a new row restarts the running max
    assign max_next = (elem_first || (in_ceil > max_q)) ? in_ceil : max_q;
    assign idx_next = elem_first ? '0 : idx_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_first <= 1'b0;
            max_q    <= '0;
            idx_cnt  <= '0;
        end else begin
            s1_valid <= accept;
            s1_first <= accept && elem_first;
            if (accept) begin
                max_q   <= max_next;
                idx_cnt <= idx_next + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_data   <= in_data;
            s1_idx    <= idx_next;
            s1_growth <= sm_shift_of(max_next, max_q);
        end
    end

    // max_q already includes the element in stage 1
    assign s1_int   = $signed(s1_data.fields.int_part);
    assign pow_frac = sm_exp_t'(SM_POW2_FRAC[s1_data.fields.frac_part]) << LUT_SCALE;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_valid    <= 1'b0;
            elem_first_d <= 1'b0;
        end else begin
            exp_valid    <= s1_valid;
            elem_first_d <= s1_first;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            exp_val    <= pow_frac >> sm_shift_of(max_q, s1_int);
            exp_idx    <= s1_idx;
            run_max    <= max_q;
            max_growth <= s1_growth;
        end
    end

endmodule

`default_nettype wire

// File: logic/prob_normalizer.sv
`timescale 1ns/1ps
`default_nettype none
`include "softermax_settings.svh"

module prob_normalizer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        div_start,
    input  softermax_num_pkg::sm_exp_t  local_exp,
    input  softermax_num_pkg::sm_int_t  local_max,
    input  softermax_num_pkg::sm_int_t  global_max,
    input  softermax_num_pkg::sm_den_t  denom,
    output logic                        div_done,
    output softermax_num_pkg::sm_prob_t quotient
);
    import softermax_num_pkg::*;

    localparam int unsigned STEP_W = $clog2(`SM_DIV_STEPS);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`SM_DIV_STEPS - 1);
    // dividend v * 2^15 reaches this far above the quotient bits
    localparam int unsigned PRE_SHIFT = `SM_DIV_STEPS - (`SM_PROB_W - 1);

    logic              busy;
    logic [STEP_W-1:0] step_cnt;
    sm_exp_t           v;
    sm_den_t           rem;
    sm_prob_t          q_sh;
    logic [`SM_DEN_W:0] trial;
    logic              q_bit;
    sm_den_t           rem_sub;
    sm_prob_t          q_next;
    sm_prob_t          q_sat;

    // rescale to the row max
    assign v = local_exp >> sm_shift_of(global_max, local_max);

    // q_sh carries the low dividend bits in and the quotient bits out
    assign trial   = {rem, q_sh[`SM_PROB_W-1]};
    assign q_bit   = (trial >= {1'b0, denom});
    assign rem_sub = sm_den_t'(trial - {1'b0, denom});
    assign q_next  = {q_sh[`SM_PROB_W-2:0], q_bit};
    assign q_sat   = (q_next > SM_PROB_ONE) ? SM_PROB_ONE : q_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            step_cnt <= '0;
            div_done <= 1'b0;
        end else begin
            div_done <= busy && (step_cnt == LAST_STEP);
            if (div_start) begin
                busy     <= 1'b1;
                step_cnt <= '0;
            end else if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (step_cnt == LAST_STEP) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            rem  <= sm_den_t'(v >> PRE_SHIFT);
            q_sh <= sm_prob_t'(v << (`SM_PROB_W - 1));
        end else if (busy) begin
            rem  <= q_bit ? rem_sub : trial[`SM_DEN_W-1:0];
            q_sh <= q_next;
            if (step_cnt == LAST_STEP) begin
                quotient <= q_sat;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/row_store.sv
`timescale 1ns/1ps
`default_nettype none
`include "softermax_settings.svh"

module row_store (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        exp_valid,
    input  softermax_ctrl_pkg::sm_idx_t exp_idx,
    input  softermax_num_pkg::sm_exp_t  exp_val,
    input  softermax_num_pkg::sm_int_t  run_max,
    input  softermax_ctrl_pkg::sm_idx_t norm_addr,
    input  logic                        prob_we,
    input  softermax_ctrl_pkg::sm_idx_t prob_waddr,
    input  softermax_num_pkg::sm_prob_t quotient,
    input  softermax_ctrl_pkg::sm_idx_t read_addr,
    output softermax_num_pkg::sm_exp_t  local_exp,
    output softermax_num_pkg::sm_int_t  local_max,
    output softermax_num_pkg::sm_prob_t prob_out
);
    import softermax_num_pkg::*;

    sm_exp_t  exp_mem  [`SM_ROW_LEN];
    sm_int_t  max_mem  [`SM_ROW_LEN];
    sm_prob_t prob_mem [`SM_ROW_LEN];

    // each exponential keeps the max it was computed against
    always_ff @(posedge clk) begin
        if (exp_valid) begin
            exp_mem[exp_idx] <= exp_val;
            max_mem[exp_idx] <= run_max;
        end
        local_exp <= exp_mem[norm_addr];
        local_max <= max_mem[norm_addr];
    end

    always_ff @(posedge clk) begin
        if (prob_we) begin
            prob_mem[prob_waddr] <= quotient;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prob_out <= '0;
        end else begin
            prob_out <= prob_mem[read_addr];
        end
    end

endmodule

`default_nettype wire

// File: logic/softermax_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "softermax_settings.svh"

module softermax_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  logic                        exp_valid,
    input  logic                        div_done,
    output logic                        accept,
    output logic                        elem_first,
    output softermax_ctrl_pkg::sm_idx_t norm_addr,
    output logic                        div_start,
    output logic                        prob_we,
    output softermax_ctrl_pkg::sm_idx_t prob_waddr,
    output logic                        norm_valid,
    output logic                        final_out_valid
);
    import softermax_ctrl_pkg::*;

    localparam sm_idx_t LAST_IDX = sm_idx_t'(`SM_ROW_LEN - 1);

    sm_phase_t phase;
    sm_idx_t   acc_cnt;
    sm_idx_t   exp_cnt;
    logic      pass1_end;
    logic      first_read;

    // scores are dropped while dividing
    assign accept          = in_valid && (phase != SM_NORM);
    assign elem_first      = accept && (acc_cnt == '0);
    assign prob_we         = div_done;
    assign norm_valid      = (phase == SM_NORM);
    assign final_out_valid = (phase == SM_DONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_cnt   <= '0;
            exp_cnt   <= '0;
            pass1_end <= 1'b0;
        end else begin
            if (accept) begin
                acc_cnt <= acc_cnt + 1'b1;
            end
            if (exp_valid) begin
                exp_cnt <= exp_cnt + 1'b1;
            end
            // set on the edge that gives the denominator its last term
            pass1_end <= exp_valid && (exp_cnt == LAST_IDX);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase      <= SM_IDLE;
            norm_addr  <= '0;
            prob_waddr <= '0;
            div_start  <= 1'b0;
            first_read <= 1'b0;
        end else begin
            div_start <= 1'b0;
            case (phase)
                SM_IDLE, SM_DONE: begin
                    if (accept) begin
                        phase <= SM_ACCUM;
                    end
                end
                SM_ACCUM: begin
                    if (pass1_end) begin
                        phase      <= SM_NORM;
                        norm_addr  <= '0;
                        prob_waddr <= '0;
                        first_read <= 1'b1;
                    end
                end
                SM_NORM: begin
                    // element 0 gets its own read cycle
                    if (first_read) begin
                        first_read <= 1'b0;
                        div_start  <= 1'b1;
                    end
                    // next element is read while this one divides
                    if (div_start) begin
                        norm_addr <= norm_addr + 1'b1;
                    end
                    if (div_done) begin
                        prob_waddr <= prob_waddr + 1'b1;
                        if (prob_waddr == LAST_IDX) begin
                            phase <= SM_DONE;
                        end else begin
                            div_start <= 1'b1;
                        end
                    end
                end
                default: phase <= SM_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/softermax_ctrl_pkg.sv
`default_nettype none
`include "softermax_settings.svh"

package softermax_ctrl_pkg;

    // idle until the first score, accum for the first pass,
    // norm for the divisions, done while the buffer holds a row
    typedef enum logic [1:0] {
        SM_IDLE,
        SM_ACCUM,
        SM_NORM,
        SM_DONE
    } sm_phase_t;

    // position within a row
    typedef logic [$clog2(`SM_ROW_LEN)-1:0] sm_idx_t;

endpackage

`default_nettype wire

// File: logic/softermax_num_pkg.sv
`default_nettype none
`include "softermax_settings.svh"

package softermax_num_pkg;

    // score split at the binary point
    typedef struct packed {
        logic signed [`SM_DATA_W-`SM_FRAC_W-1:0] int_part;
        logic        [`SM_FRAC_W-1:0]            frac_part;
    } sm_score_fields_t;

    typedef union packed {
        logic signed [`SM_DATA_W-1:0] raw;
        sm_score_fields_t             fields;
    } sm_data_t;

    // one bit wider than int_part, ceiling of 31.75 is 32
    typedef logic signed [`SM_DATA_W-`SM_FRAC_W:0] sm_int_t;
    typedef logic [`SM_EXP_W-1:0]  sm_exp_t;
    typedef logic [`SM_DEN_W-1:0]  sm_den_t;
    typedef logic [`SM_PROB_W-1:0] sm_prob_t;
    // amounts of 16 or more clear a 16-bit word
    typedef logic [4:0]            sm_shift_t;

    // 2^(f/4) in units of 1/16
    localparam int unsigned SM_POW2_UNIT_W = 4;
    localparam logic [(1<<`SM_FRAC_W)-1:0][SM_POW2_UNIT_W:0] SM_POW2_FRAC =
        {5'd27, 5'd23, 5'd19, 5'd16};

    localparam sm_prob_t SM_PROB_ONE = sm_prob_t'(1) << (`SM_PROB_W - 1);

    // hi - lo as a shift, clamped to the shift range
    function automatic sm_shift_t sm_shift_of(input sm_int_t hi, input sm_int_t lo);
        logic signed [`SM_DATA_W-`SM_FRAC_W+1:0] diff;
        diff = hi - lo;
        if (diff < 0) begin
            return '0;
        end
        if (diff > 31) begin
            return '1;
        end
        return sm_shift_t'(diff);
    endfunction

endpackage

`default_nettype wire

// File: logic/softermax_top.sv
`timescale 1ns/1ps
`default_nettype none

module softermax_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  softermax_num_pkg::sm_data_t in_data,
    input  softermax_ctrl_pkg::sm_idx_t read_addr,
    output logic                        norm_valid,
    output logic                        final_out_valid,
    output softermax_num_pkg::sm_prob_t prob_out
);
    import softermax_num_pkg::*;
    import softermax_ctrl_pkg::*;

    logic      accept;
    logic      elem_first;
    logic      exp_valid;
    sm_idx_t   exp_idx;
    sm_exp_t   exp_val;
    sm_int_t   run_max;
    sm_shift_t max_growth;
    logic      elem_first_d;
    sm_den_t   denom;
    sm_idx_t   norm_addr;
    sm_exp_t   local_exp;
    sm_int_t   local_max;
    logic      div_start;
    logic      div_done;
    sm_prob_t  quotient;
    logic      prob_we;
    sm_idx_t   prob_waddr;

    softermax_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .exp_valid       (exp_valid),
        .div_done        (div_done),
        .accept          (accept),
        .elem_first      (elem_first),
        .norm_addr       (norm_addr),
        .div_start       (div_start),
        .prob_we         (prob_we),
        .prob_waddr      (prob_waddr),
        .norm_valid      (norm_valid),
        .final_out_valid (final_out_valid)
    );

    online_exp_unit u_exp (
        .clk          (clk),
        .rst_n        (rst_n),
        .accept       (accept),
        .elem_first   (elem_first),
        .in_data      (in_data),
        .exp_valid    (exp_valid),
        .exp_idx      (exp_idx),
        .exp_val      (exp_val),
        .run_max      (run_max),
        .max_growth   (max_growth),
        .elem_first_d (elem_first_d)
    );

    denom_accum u_denom (
        .clk          (clk),
        .rst_n        (rst_n),
        .exp_valid    (exp_valid),
        .elem_first_d (elem_first_d),
        .exp_val      (exp_val),
        .max_growth   (max_growth),
        .denom        (denom)
    );

    row_store u_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .exp_valid  (exp_valid),
        .exp_idx    (exp_idx),
        .exp_val    (exp_val),
        .run_max    (run_max),
        .norm_addr  (norm_addr),
        .prob_we    (prob_we),
        .prob_waddr (prob_waddr),
        .quotient   (quotient),
        .read_addr  (read_addr),
        .local_exp  (local_exp),
        .local_max  (local_max),
        .prob_out   (prob_out)
    );

    // run_max holds the row maximum once the first pass ends
    prob_normalizer u_norm (
        .clk        (clk),
        .rst_n      (rst_n),
        .div_start  (div_start),
        .local_exp  (local_exp),
        .local_max  (local_max),
        .global_max (run_max),
        .denom      (denom),
        .div_done   (div_done),
        .quotient   (quotient)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module tb_softermax -o tb_softermax \
    || { echo "build failed"; exit 1; }

out="$(./obj_dir/tb_softermax)"
echo "$out"
grep -qx "Testbench passed" <<< "$out" && exit 0 || exit 1
